//--- arp_engine.f
arp_pkg.sv
arp_msg_if.sv
arp_rx.sv
arp_tx.sv
arp_table.sv
arp_engine.sv
arp_clk_gen.sv
arp_checker.sv
tb_arp_engine.sv

//--- tb_arp_engine.sv
`default_nettype none

module tb_arp_engine import arp_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DRIVE_DELAY     = 1;
  localparam int NUM_TESTS       = 11;
  localparam int CYCLES_PER_TEST = 200;
  localparam int QUIET_CYCLES    = 100;
  localparam int RX_GAP          = 4;  // idle cycles after each received frame

  typedef logic [ARP_FRAME_BYTES*8-1:0] frame_t;  // byte i sits in bits [8i+7:8i]

  logic       clk;
  logic       reset;
  mac_addr_t  my_mac;
  ipv4_addr_t my_ip;
  byte_t      rx_data;
  logic       rx_valid;
  logic       rx_last;
  byte_t      tx_data;
  logic       tx_valid;
  logic       tx_last;
  logic       tx_credit;
  logic       lookup_valid;
  ipv4_addr_t lookup_ip;
  logic       lookup_done;
  logic       lookup_hit;
  mac_addr_t  lookup_mac;

  frame_t exp_q[$];
  frame_t got_q[$];
  frame_t cur_frame;
  int     cur_len;
  int     bytes_seen;
  int     frames_expected;
  int     frames_checked;
  int     owed;           // bytes sent and not yet credited back
  bit     credit_sparse;
  string  test_name;

  arp_clk_gen u_clk_gen (
    .clk   (clk),
    .reset (reset)
  );

  arp_engine u_arp_engine (
    .clk          (clk),
    .reset        (reset),
    .my_mac       (my_mac),
    .my_ip        (my_ip),
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .rx_last      (rx_last),
    .tx_data      (tx_data),
    .tx_valid     (tx_valid),
    .tx_last      (tx_last),
    .tx_credit    (tx_credit),
    .lookup_valid (lookup_valid),
    .lookup_ip    (lookup_ip),
    .lookup_done  (lookup_done),
    .lookup_hit   (lookup_hit),
    .lookup_mac   (lookup_mac)
  );

  bind arp_engine arp_checker u_checker (
    .clk          (clk),
    .reset        (reset),
    .tx_valid     (tx_valid),
    .tx_last      (tx_last),
    .tx_credit    (tx_credit),
    .lookup_valid (lookup_valid),
    .lookup_done  (lookup_done)
  );

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped");
  endtask

  task automatic check_byte(int idx, byte_t exp, byte_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s: tx byte %0d expected %02h actual %02h",
                          test_name, idx, exp, act));
    end
  endtask

  task automatic check_mac(mac_addr_t exp, mac_addr_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s: lookup_mac expected %012h actual %012h",
                          test_name, exp, act));
    end
  endtask

  task automatic check_hit(logic exp, logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s: lookup_hit expected %0b actual %0b", test_name, exp, act));
    end
  endtask

  // append the n low bytes of val, most significant first
  function automatic void put_bytes(ref frame_t f, ref int pos, input logic [47:0] val,
                                    input int n);
    for (int i = n - 1; i >= 0; i--) begin
      f[8*pos +: 8] = val[8*i +: 8];
      pos++;
    end
  endfunction

  function automatic frame_t arp_bytes(mac_addr_t dst, mac_addr_t src, logic [15:0] etype,
                                       arp_oper_t oper, mac_addr_t sha, ipv4_addr_t spa,
                                       mac_addr_t tha, ipv4_addr_t tpa);
    frame_t f;
    int     pos;
    f   = '0;
    pos = 0;
    put_bytes(f, pos, dst, 6);
    put_bytes(f, pos, src, 6);
    put_bytes(f, pos, etype, 2);
    put_bytes(f, pos, ARP_HTYPE_ETH, 2);
    put_bytes(f, pos, ARP_PTYPE_IPV4, 2);
    put_bytes(f, pos, 48'd6, 1);  // hlen
    put_bytes(f, pos, 48'd4, 1);  // plen
    put_bytes(f, pos, oper, 2);
    put_bytes(f, pos, sha, 6);
    put_bytes(f, pos, spa, 4);
    put_bytes(f, pos, tha, 6);
    put_bytes(f, pos, tpa, 4);
    return f;
  endfunction

  // expected frame sent by this host
  function automatic frame_t build_frame(arp_oper_t oper, mac_addr_t dst, mac_addr_t tha,
                                         ipv4_addr_t tpa);
    return arp_bytes(dst, my_mac, ETHERTYPE_ARP, oper, my_mac, my_ip, tha, tpa);
  endfunction

  // well formed frame from a peer
  function automatic frame_t peer_frame(arp_oper_t oper, mac_addr_t sha, ipv4_addr_t spa,
                                        ipv4_addr_t tpa);
    return arp_bytes(MAC_BROADCAST, sha, ETHERTYPE_ARP, oper, sha, spa, '0, tpa);
  endfunction

  function automatic mac_addr_t rand_mac();
    return {16'($urandom()), 32'($urandom())};
  endfunction

  function automatic ipv4_addr_t rand_ip(byte_t net);
    return {net, 24'($urandom())};
  endfunction

  task automatic tick();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic send_rx_frame(frame_t f, int len);
    for (int i = 0; i < len; i++) begin
      tick();
      rx_valid = 1'b1;
      rx_data  = (i < ARP_FRAME_BYTES) ? f[8*i +: 8] : 8'h00;
      rx_last  = (i == len - 1);
    end
    tick();
    rx_valid = 1'b0;
    rx_last  = 1'b0;
    rx_data  = '0;
    repeat (RX_GAP) tick();
  endtask

  task automatic expect_frame(frame_t f);
    exp_q.push_back(f);
    frames_expected++;
  endtask

  task automatic wait_frames_done();
    while (frames_checked != frames_expected) tick();
  endtask

  task automatic expect_quiet(int cycles);
    int start;
    start = bytes_seen;
    repeat (cycles) tick();
    if (bytes_seen != start) begin
      abort_run($sformatf("%s: the DUT transmitted while it should stay silent", test_name));
    end
  endtask

  // a miss always triggers a broadcast request for the same ip
  task automatic lookup_expect(ipv4_addr_t ip, logic exp_hit, mac_addr_t exp_mac);
    if (!exp_hit) expect_frame(build_frame(ARP_OPER_REQUEST, MAC_BROADCAST, '0, ip));
    tick();
    lookup_valid = 1'b1;
    lookup_ip    = ip;
    tick();
    lookup_valid = 1'b0;
    do @(negedge clk); while (!lookup_done);
    check_hit(exp_hit, lookup_hit);
    if (exp_hit) check_mac(exp_mac, lookup_mac);
    wait_frames_done();
  endtask

  // transmit monitor, sampled mid cycle
  always @(negedge clk) begin
    if (!reset && tx_valid) begin
      if (cur_len >= ARP_FRAME_BYTES) abort_run("transmit frame runs past 42 bytes");
      cur_frame[8*cur_len +: 8] = tx_data;
      cur_len++;
      bytes_seen++;
      owed++;
      if (tx_last) begin
        if (cur_len != ARP_FRAME_BYTES) begin
          abort_run($sformatf("transmit frame ended after %0d bytes", cur_len));
        end
        got_q.push_back(cur_frame);
        cur_len = 0;
      end
    end
  end

  always @(posedge clk) begin : compare_frames
    frame_t got;
    frame_t exp;
    while (got_q.size() > 0) begin
      got = got_q.pop_front();
      if (exp_q.size() == 0) begin
        abort_run($sformatf("%s: a frame was transmitted when none was expected", test_name));
      end else begin
        exp = exp_q.pop_front();
        for (int i = 0; i < ARP_FRAME_BYTES; i++) check_byte(i, exp[8*i +: 8], got[8*i +: 8]);
        frames_checked++;
      end
    end
  end

  // credit return, one per sent byte, sparse and random when asked
  always @(posedge clk) begin
    #DRIVE_DELAY;
    tx_credit = 1'b0;
    if (owed > 0 && (!credit_sparse || $urandom_range(2) == 0)) begin
      tx_credit = 1'b1;
      owed--;
    end
  end

  always @(posedge clk) begin
    if (u_arp_engine.u_checker.fail_count != 0) abort_run("an assertion in the checker failed");
  end

  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    abort_run("watchdog timeout: the tests did not finish in time, the DUT seems to hang");
  end

  initial begin
    mac_addr_t  peer_mac;
    ipv4_addr_t peer_ip;
    ipv4_addr_t ips[9];
    mac_addr_t  macs[9];
    ipv4_addr_t bad_ips[4];
    logic [15:0] base;
    frame_t     f;
    int         len;

    void'($urandom(32'hae1f));
    rx_data         = '0;
    rx_valid        = 1'b0;
    rx_last         = 1'b0;
    tx_credit       = 1'b0;
    lookup_valid    = 1'b0;
    lookup_ip       = '0;
    credit_sparse   = 1'b0;
    cur_len         = 0;
    bytes_seen      = 0;
    frames_expected = 0;
    frames_checked  = 0;
    owed            = 0;
    test_name       = "reset";
    my_mac          = rand_mac();
    my_ip           = rand_ip(8'd192);
    do @(negedge clk); while (reset);

    test_name = "reply";
    peer_mac  = rand_mac();
    peer_ip   = rand_ip(8'd10);
    expect_frame(build_frame(ARP_OPER_REPLY, peer_mac, peer_mac, peer_ip));
    send_rx_frame(peer_frame(ARP_OPER_REQUEST, peer_mac, peer_ip, my_ip), ARP_FRAME_BYTES);
    wait_frames_done();
    test_name = "learn_from_request";
    lookup_expect(peer_ip, 1'b1, peer_mac);

    test_name = "other_target";
    peer_mac  = rand_mac();
    peer_ip   = rand_ip(8'd10);
    send_rx_frame(peer_frame(ARP_OPER_REQUEST, peer_mac, peer_ip, rand_ip(8'd10)),
                  ARP_FRAME_BYTES);
    expect_quiet(QUIET_CYCLES);
    lookup_expect(peer_ip, 1'b1, peer_mac);

    test_name = "unknown_ip";
    lookup_expect(rand_ip(8'd11), 1'b0, '0);

    test_name     = "sparse_credits";
    credit_sparse = 1'b1;
    peer_mac      = rand_mac();
    peer_ip       = rand_ip(8'd10);
    expect_frame(build_frame(ARP_OPER_REPLY, peer_mac, peer_mac, peer_ip));
    send_rx_frame(peer_frame(ARP_OPER_REQUEST, peer_mac, peer_ip, my_ip), ARP_FRAME_BYTES);
    lookup_expect(rand_ip(8'd11), 1'b0, '0);  // request queued behind the reply
    credit_sparse = 1'b0;

    // 9 new ips, the ninth replaces the first by round robin
    test_name = "evict";
    base      = 16'($urandom());
    for (int i = 0; i < 9; i++) begin
      ips[i]  = {8'd172, base, 8'(i)};
      macs[i] = rand_mac();
      send_rx_frame(peer_frame(ARP_OPER_REPLY, macs[i], ips[i], my_ip), ARP_FRAME_BYTES);
    end
    lookup_expect(ips[0], 1'b0, '0);
    for (int i = 1; i < 9; i++) lookup_expect(ips[i], 1'b1, macs[i]);

    test_name = "relearn";
    macs[3]   = rand_mac();
    send_rx_frame(peer_frame(ARP_OPER_REPLY, macs[3], ips[3], my_ip), ARP_FRAME_BYTES);
    for (int i = 1; i < 9; i++) lookup_expect(ips[i], 1'b1, macs[i]);

    for (int k = 0; k < 4; k++) begin
      bad_ips[k] = rand_ip(8'd12);
      peer_mac   = rand_mac();
      len        = ARP_FRAME_BYTES;
      f          = peer_frame(ARP_OPER_REQUEST, peer_mac, bad_ips[k], my_ip);
      case (k)
        0: begin
          test_name = "bad_ethertype";
          f = arp_bytes(MAC_BROADCAST, peer_mac, 16'h0800, ARP_OPER_REQUEST, peer_mac,
                        bad_ips[k], '0, my_ip);
        end
        1: begin
          test_name = "short_frame";
          len       = ARP_FRAME_BYTES - 1;
        end
        2: begin
          test_name = "long_frame";
          len       = ARP_FRAME_BYTES + 1;
        end
        default: begin
          test_name = "bad_oper";
          f         = peer_frame(arp_oper_t'(3), peer_mac, bad_ips[k], my_ip);
        end
      endcase
      send_rx_frame(f, len);
    end
    test_name = "malformed_dropped";
    expect_quiet(QUIET_CYCLES);
    for (int k = 0; k < 4; k++) lookup_expect(bad_ips[k], 1'b0, '0);

    repeat (10) tick();
    if (u_arp_engine.u_checker.fail_count == 0 && exp_q.size() == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("ERRORS FOUND");
      $fatal(1, "expected frames missing or assertions failed");
    end
  end

endmodule

`default_nettype wire

//--- arp_checker.sv
`default_nettype none

module arp_checker import arp_pkg::*; (
  input logic clk,
  input logic reset,
  input logic tx_valid,
  input logic tx_last,
  input logic tx_credit,
  input logic lookup_valid,
  input logic lookup_done
);

  timeunit 1ns;
  timeprecision 100ps;

  credit_t     credits;         // own model of the transmit credit count
  logic [5:0]  beats;           // bytes since the last tx_last
  int unsigned fail_count = 0;  // read by the testbench

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= TX_CREDITS;
      beats   <= '0;
    end else begin
      if (tx_valid && !tx_credit) begin
        credits <= credits - 3'd1;
      end else if (!tx_valid && tx_credit && credits != TX_CREDITS) begin
        credits <= credits + 3'd1;
      end
      if (tx_valid) beats <= tx_last ? 6'd0 : beats + 6'd1;
    end
  end

  a_credit: assert property (@(posedge clk) disable iff (reset) tx_valid |-> credits != '0)
    else begin $error("tx byte sent with no credit left"); fail_count++; end

  a_lookup_latency: assert property (@(posedge clk) disable iff (reset)
    lookup_valid |-> ##2 lookup_done)
    else begin $error("lookup_done did not follow lookup_valid by 2 cycles"); fail_count++; end

  a_lookup_origin: assert property (@(posedge clk) disable iff (reset)
    lookup_done |-> $past(lookup_valid, 2))
    else begin $error("lookup_done without a lookup 2 cycles earlier"); fail_count++; end

  // tx_last sits on byte 42
  a_frame_len: assert property (@(posedge clk) disable iff (reset)
    tx_last |-> tx_valid && beats == 6'(ARP_FRAME_BYTES - 1))
    else begin $error("tx_last not preceded by exactly 41 bytes"); fail_count++; end

endmodule

`default_nettype wire

//--- arp_clk_gen.sv
`default_nettype none

module arp_clk_gen (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 2;  // 4 ns clock
  localparam int RESET_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;  // released just after the edge like any other input
  end

endmodule

`default_nettype wire

//--- arp_engine.sv
`default_nettype none

module arp_engine import arp_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  mac_addr_t  my_mac,
  input  ipv4_addr_t my_ip,
  input  byte_t      rx_data,
  input  logic       rx_valid,
  input  logic       rx_last,
  output byte_t      tx_data,
  output logic       tx_valid,
  output logic       tx_last,
  input  logic       tx_credit,
  input  logic       lookup_valid,
  input  ipv4_addr_t lookup_ip,
  output logic       lookup_done,
  output logic       lookup_hit,
  output mac_addr_t  lookup_mac
);

  arp_msg_if rx_msg ();
  arp_msg_if tx_msg ();

  logic       learn_valid;
  ipv4_addr_t learn_ip;
  mac_addr_t  learn_mac;
  logic       req_valid;
  ipv4_addr_t req_ip;
  logic       req_taken;
  logic       tx_busy;

  logic       for_me;
  logic       pend_valid;
  mac_addr_t  pend_mac;
  ipv4_addr_t pend_ip;
  logic       send_reply;

  arp_rx u_rx (
    .clk         (clk),
    .reset       (reset),
    .my_ip       (my_ip),
    .rx_data     (rx_data),
    .rx_valid    (rx_valid),
    .rx_last     (rx_last),
    .msg         (rx_msg.src),
    .learn_valid (learn_valid),
    .learn_ip    (learn_ip),
    .learn_mac   (learn_mac)
  );

  arp_table u_table (
    .clk          (clk),
    .reset        (reset),
    .learn_valid  (learn_valid),
    .learn_ip     (learn_ip),
    .learn_mac    (learn_mac),
    .lookup_valid (lookup_valid),
    .lookup_ip    (lookup_ip),
    .lookup_done  (lookup_done),
    .lookup_hit   (lookup_hit),
    .lookup_mac   (lookup_mac),
    .req_valid    (req_valid),
    .req_ip       (req_ip),
    .req_taken    (req_taken)
  );

  arp_tx u_tx (
    .clk       (clk),
    .reset     (reset),
    .my_mac    (my_mac),
    .my_ip     (my_ip),
    .msg       (tx_msg.dst),
    .tx_data   (tx_data),
    .tx_valid  (tx_valid),
    .tx_last   (tx_last),
    .tx_credit (tx_credit),
    .tx_busy   (tx_busy)
  );

  assign for_me = rx_msg.valid && (rx_msg.oper == ARP_OPER_REQUEST) &&
                  (rx_msg.target_ip == my_ip);

  // pending reply wins over a table request
  assign send_reply = pend_valid && !tx_busy;
  assign req_taken  = req_valid && !pend_valid && !tx_busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      pend_valid   <= 1'b0;
      tx_msg.valid <= 1'b0;
    end else begin
      tx_msg.valid <= send_reply || req_taken;
      if (send_reply) pend_valid <= 1'b0;
      if (for_me && !pend_valid) pend_valid <= 1'b1;  // extra reply is dropped
    end
  end

  always_ff @(posedge clk) begin
    if (for_me && !pend_valid) begin
      pend_mac <= rx_msg.peer_mac;
      pend_ip  <= rx_msg.peer_ip;
    end
    if (send_reply) begin
      tx_msg.oper      <= ARP_OPER_REPLY;
      tx_msg.peer_mac  <= pend_mac;
      tx_msg.peer_ip   <= pend_ip;
      tx_msg.target_ip <= pend_ip;
    end else if (req_taken) begin
      tx_msg.oper      <= ARP_OPER_REQUEST;
      tx_msg.peer_mac  <= MAC_BROADCAST;
      tx_msg.peer_ip   <= req_ip;
      tx_msg.target_ip <= req_ip;
    end
  end

endmodule

`default_nettype wire

//--- arp_table.sv
`default_nettype none

module arp_table import arp_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       learn_valid,
  input  ipv4_addr_t learn_ip,
  input  mac_addr_t  learn_mac,
  input  logic       lookup_valid,
  input  ipv4_addr_t lookup_ip,
  output logic       lookup_done,
  output logic       lookup_hit,
  output mac_addr_t  lookup_mac,
  output logic       req_valid,
  output ipv4_addr_t req_ip,
  input  logic       req_taken
);

  logic [ARP_TABLE_SIZE-1:0] ent_valid;
  ipv4_addr_t                ent_ip  [ARP_TABLE_SIZE];
  mac_addr_t                 ent_mac [ARP_TABLE_SIZE];
  tbl_idx_t                  rr_ptr;

  logic                      lrn_v;
  ipv4_addr_t                lrn_ip;
  mac_addr_t                 lrn_mac;
  logic [ARP_TABLE_SIZE-1:0] lrn_match;
  tbl_idx_t                  wr_idx;

  logic [ARP_TABLE_SIZE-1:0] lk_cmp;
  logic [ARP_TABLE_SIZE-1:0] lk_match;  // stage 1 result
  logic                      lk_v;
  ipv4_addr_t                lk_ip;

  function automatic tbl_idx_t first_set(logic [ARP_TABLE_SIZE-1:0] vec);
    tbl_idx_t idx;
    idx = '0;
    for (int i = ARP_TABLE_SIZE - 1; i >= 0; i--) begin
      if (vec[i]) idx = tbl_idx_t'(i);
    end
    return idx;
  endfunction

  always_comb begin
    for (int i = 0; i < ARP_TABLE_SIZE; i++) begin
      lrn_match[i] = ent_valid[i] && (ent_ip[i] == lrn_ip);
      lk_cmp[i]    = ent_valid[i] && (ent_ip[i] == lookup_ip);
    end
  end

  // existing ip is overwritten in place, otherwise round robin victim
  assign wr_idx = (|lrn_match) ? first_set(lrn_match) : rr_ptr;

  always_ff @(posedge clk) begin
    if (reset) begin
      lrn_v       <= 1'b0;
      ent_valid   <= '0;
      rr_ptr      <= '0;
      lk_v        <= 1'b0;
      lookup_done <= 1'b0;
      lookup_hit  <= 1'b0;
      req_valid   <= 1'b0;
    end else begin
      lrn_v <= learn_valid;
      if (lrn_v) begin
        ent_valid[wr_idx] <= 1'b1;
        if (!(|lrn_match)) rr_ptr <= rr_ptr + 3'd1;
      end

      lk_v        <= lookup_valid;
      lookup_done <= lk_v;
      lookup_hit  <= lk_v && (|lk_match);

      if (req_taken) req_valid <= 1'b0;
      if (lk_v && !(|lk_match) && !req_valid) req_valid <= 1'b1;  // one pending at most
    end
  end

  always_ff @(posedge clk) begin
    if (learn_valid) begin
      lrn_ip  <= learn_ip;
      lrn_mac <= learn_mac;
    end
    if (lrn_v) begin
      ent_ip[wr_idx]  <= lrn_ip;
      ent_mac[wr_idx] <= lrn_mac;
    end
    lk_match   <= lk_cmp;
    lk_ip      <= lookup_ip;
    lookup_mac <= ent_mac[first_set(lk_match)];
    if (lk_v && !(|lk_match) && !req_valid) req_ip <= lk_ip;
  end

endmodule

`default_nettype wire

//--- arp_tx.sv
`default_nettype none

module arp_tx import arp_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  mac_addr_t  my_mac,
  input  ipv4_addr_t my_ip,
  arp_msg_if.dst     msg,
  output byte_t      tx_data,
  output logic       tx_valid,
  output logic       tx_last,
  input  logic       tx_credit,
  output logic       tx_busy
);

  typedef enum logic {
    TX_IDLE,
    TX_SEND
  } tx_state_t;

  tx_state_t  state;
  logic [5:0] idx;      // byte index within the frame
  credit_t    credits;
  arp_oper_t  oper_q;
  mac_addr_t  dst_mac_q;
  mac_addr_t  tha_q;
  ipv4_addr_t tpa_q;
  logic [ARP_FRAME_BYTES*8-1:0] frame;

  assign frame = {
    dst_mac_q,
    my_mac,
    ETHERTYPE_ARP,
    ARP_HTYPE_ETH,
    ARP_PTYPE_IPV4,
    ARP_HLEN,
    ARP_PLEN,
    oper_q,
    my_mac,          // sender hw address
    my_ip,           // sender protocol address
    tha_q,
    tpa_q
  };

  assign tx_data  = frame[8 * (ARP_FRAME_BYTES - 1 - int'(idx)) +: 8];
  assign tx_valid = (state == TX_SEND) && (credits != '0);
  assign tx_last  = tx_valid && (idx == 6'(ARP_FRAME_BYTES - 1));
  assign tx_busy  = (state == TX_SEND) || msg.valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= TX_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (msg.valid) begin
            state <= TX_SEND;
            idx   <= '0;
          end
        end
        TX_SEND: begin
          if (tx_valid) begin
            idx <= idx + 6'd1;
            if (tx_last) state <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // one credit per byte, returned by tx_credit pulses
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= TX_CREDITS;
    end else begin
      case ({tx_valid, tx_credit})
        2'b10: credits <= credits - 3'd1;
        2'b01: if (credits != TX_CREDITS) credits <= credits + 3'd1;
        default: credits <= credits;  // spend and return cancel out
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == TX_IDLE && msg.valid) begin
      oper_q    <= msg.oper;
      dst_mac_q <= msg.peer_mac;
      tha_q     <= (msg.oper == ARP_OPER_REQUEST) ? '0 : msg.peer_mac;
      tpa_q     <= msg.target_ip;
    end
  end

endmodule

`default_nettype wire

//--- arp_rx.sv
`default_nettype none

module arp_rx import arp_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  ipv4_addr_t my_ip,
  input  byte_t      rx_data,
  input  logic       rx_valid,
  input  logic       rx_last,
  arp_msg_if.src     msg,
  output logic       learn_valid,
  output ipv4_addr_t learn_ip,
  output mac_addr_t  learn_mac
);

  logic [5:0] cnt;        // offset of the byte on rx_data
  logic       err;        // sticky until rx_last
  logic       byte_bad;
  logic       frame_ok;
  logic       msg_valid;
  arp_oper_t  oper;
  mac_addr_t  sha;
  ipv4_addr_t spa;
  ipv4_addr_t tpa;

  // fixed header bytes
  always_comb begin
    case (cnt)
      6'd12:   byte_bad = rx_data != ETHERTYPE_ARP[15:8];
      6'd13:   byte_bad = rx_data != ETHERTYPE_ARP[7:0];
      6'd14:   byte_bad = rx_data != ARP_HTYPE_ETH[15:8];
      6'd15:   byte_bad = rx_data != ARP_HTYPE_ETH[7:0];
      6'd16:   byte_bad = rx_data != ARP_PTYPE_IPV4[15:8];
      6'd17:   byte_bad = rx_data != ARP_PTYPE_IPV4[7:0];
      6'd18:   byte_bad = rx_data != ARP_HLEN;
      6'd19:   byte_bad = rx_data != ARP_PLEN;
      default: byte_bad = 1'b0;
    endcase
  end

  // evaluated on the beat carrying rx_last
  assign frame_ok = !err && !byte_bad &&
                    (cnt == 6'(ARP_FRAME_BYTES - 1)) &&
                    (oper == ARP_OPER_REQUEST || oper == ARP_OPER_REPLY);

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt         <= '0;
      err         <= 1'b0;
      msg_valid   <= 1'b0;
      learn_valid <= 1'b0;
    end else begin
      msg_valid   <= 1'b0;
      learn_valid <= 1'b0;
      if (rx_valid) begin
        if (rx_last) begin
          cnt         <= '0;
          err         <= 1'b0;
          msg_valid   <= frame_ok;
          learn_valid <= frame_ok && (spa != my_ip);  // never learn our own ip
        end else begin
          cnt <= cnt + 6'd1;
          // a byte past offset 41 means the frame is too long
          err <= err | byte_bad | (cnt == 6'(ARP_FRAME_BYTES - 1));
        end
      end
    end
  end

  // field capture, network byte order
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      if (cnt inside {[6'd20:6'd21]}) oper <= {oper[7:0], rx_data};
      if (cnt inside {[6'd22:6'd27]}) sha <= {sha[39:0], rx_data};
      if (cnt inside {[6'd28:6'd31]}) spa <= {spa[23:0], rx_data};
      if (cnt inside {[6'd38:6'd41]}) tpa <= {tpa[23:0], rx_data};
    end
  end

  assign msg.valid     = msg_valid;
  assign msg.oper      = oper;
  assign msg.peer_mac  = sha;
  assign msg.peer_ip   = spa;
  assign msg.target_ip = tpa;

  assign learn_ip  = spa;
  assign learn_mac = sha;

endmodule

`default_nettype wire

//--- arp_msg_if.sv
`default_nettype none

// one arp message, received or about to be sent
interface arp_msg_if import arp_pkg::*; ();

  logic       valid;      // single cycle strobe
  arp_oper_t  oper;
  mac_addr_t  peer_mac;   // on the send side this is the destination mac
  ipv4_addr_t peer_ip;
  ipv4_addr_t target_ip;

  modport src (
    output valid,
    output oper,
    output peer_mac,
    output peer_ip,
    output target_ip
  );

  modport dst (
    input valid,
    input oper,
    input peer_mac,
    input peer_ip,
    input target_ip
  );

endinterface

`default_nettype wire

//--- arp_pkg.sv
`default_nettype none

package arp_pkg;

  // field types
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] arp_oper_t;
  typedef logic [7:0]  byte_t;
  typedef logic [2:0]  tbl_idx_t;  // log2 of ARP_TABLE_SIZE
  typedef logic [2:0]  credit_t;

  // arp operation codes
  localparam arp_oper_t ARP_OPER_REQUEST = 16'd1;
  localparam arp_oper_t ARP_OPER_REPLY   = 16'd2;

  // header constants
  localparam logic [15:0] ETHERTYPE_ARP  = 16'h0806;
  localparam logic [15:0] ARP_HTYPE_ETH  = 16'd1;
  localparam logic [15:0] ARP_PTYPE_IPV4 = 16'h0800;
  localparam byte_t       ARP_HLEN       = 8'd6;
  localparam byte_t       ARP_PLEN       = 8'd4;

  // 14 byte ethernet header plus 28 byte arp body, no padding or fcs
  localparam int ARP_FRAME_BYTES = 42;

  localparam int ARP_TABLE_SIZE = 8;

  localparam credit_t TX_CREDITS = 3'd4;  // credits held after reset

  localparam mac_addr_t MAC_BROADCAST = 48'hffff_ffff_ffff;

endpackage

`default_nettype wire
